// ==== source/m107_io_pkg.sv ====
`default_nettype none

package m107_io_pkg;

    // ====================
    // AXI4-Lite channels
    // ====================

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [15:0] wdata;
        logic [1:0]  wstrb;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic       arvalid;
        logic [7:0] araddr;
        logic       rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic        arready;
        logic        rvalid;
        logic [15:0] rdata;
        logic [1:0]  rresp;
    } axil_rd_rsp_t;

    // ====================
    // Board side
    // ====================

    typedef struct packed {
        logic [3:0] coin;
        logic [3:0] start;
        logic [9:0] p1;
        logic [9:0] p2;
        logic [9:0] p3;
        logic [9:0] p4;
    } player_inputs_t;

    // Read words in the active low form the CPU sees
    typedef struct packed {
        logic [15:0] switches_p12;
        logic [15:0] flags;
        logic [15:0] dip_low;
        logic [15:0] switches_p34;
    } io_read_words_t;

    typedef struct packed {
        logic [1:0] coin_counter;
        logic       screen_flip;
        logic       color_blank;
        logic       bus_request;
        logic       bank_enable;
        logic [3:0] bank_select;
        logic       sound_reset;
    } sys_ctrl_t;

    typedef logic [7:0] snd_cmd_t;

    // ====================
    // Port map
    // ====================

    localparam logic [7:0] addr_switches_p12 = 8'h00;
    localparam logic [7:0] addr_flags        = 8'h02;
    localparam logic [7:0] addr_dip          = 8'h04;
    localparam logic [7:0] addr_switches_p34 = 8'h06;
    localparam logic [7:0] addr_sound_reply  = 8'h08;
    localparam logic [7:0] addr_bank         = 8'h20;
    localparam logic [7:0] addr_sound_reset  = 8'hc0;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    localparam logic [15:0] unmapped_read_value = 16'hffff;

endpackage

`default_nettype wire

// ==== source/switch_mapper.sv ====
`default_nettype none

module switch_mapper (
    input  m107_io_pkg::player_inputs_t  inputs,
    input  wire                          kick_harness,
    input  wire [23:0]                   dip_sw,
    input  wire                          dma_busy,
    output m107_io_pkg::io_read_words_t  words
);

    import m107_io_pkg::*;

    logic [7:0] byte_p1;
    logic [7:0] byte_p2;
    logic [7:0] byte_p3;
    logic [7:0] byte_p4;

    // Button 7 of players 1 and 2 is only wired on the kick harness
    function automatic logic [7:0] main_byte(input logic [9:0] p, input logic kick);
        main_byte = {p[4], p[5], kick & p[6], 1'b0, p[3:0]};
    endfunction

    // Players 3 and 4 on the standard harness carry their own coin and start
    function automatic logic [7:0] aux_byte(input logic [9:0] p, input logic coin,
                                            input logic start);
        aux_byte = {p[4], p[5], coin, start, p[3:0]};
    endfunction

    always_comb begin
        byte_p1 = main_byte(inputs.p1, kick_harness);
        byte_p2 = main_byte(inputs.p2, kick_harness);
        if (kick_harness) begin
            byte_p3 = 8'h00;
            byte_p4 = {inputs.p2[9], inputs.p2[8], inputs.p2[7], 1'b0,
                       inputs.p1[9], inputs.p1[8], inputs.p1[7], 1'b0};
        end else begin
            byte_p3 = aux_byte(inputs.p3, inputs.coin[2], inputs.start[2]);
            byte_p4 = aux_byte(inputs.p4, inputs.coin[3], inputs.start[3]);
        end
    end

    // Everything reads back active low
    assign words.switches_p12 = {~byte_p2, ~byte_p1};
    assign words.switches_p34 = {~byte_p4, ~byte_p3};
    assign words.dip_low      = ~dip_sw[15:0];

    // Test and R lines are not connected and read high
    assign words.flags = {~dip_sw[23:16], ~dma_busy, 3'b111,
                          ~inputs.coin[1:0], ~inputs.start[1:0]};

endmodule

`default_nettype wire

// ==== source/io_port_decoder.sv ====
`default_nettype none

module io_port_decoder (
    input  wire                          clk_sys,
    input  wire                          reset_n,

    input  m107_io_pkg::axil_wr_req_t    wr_req,
    output m107_io_pkg::axil_wr_rsp_t    wr_rsp,
    input  m107_io_pkg::axil_rd_req_t    rd_req,
    output m107_io_pkg::axil_rd_rsp_t    rd_rsp,

    input  m107_io_pkg::io_read_words_t  words,
    input  wire                          dip_flip,
    output m107_io_pkg::sys_ctrl_t       sys_ctrl,

    output logic                         cmd_push,
    output m107_io_pkg::snd_cmd_t        cmd_data,
    input  wire                          cmd_full,

    input  m107_io_pkg::snd_cmd_t        reply_data,
    output logic                         reply_taken
);

    import m107_io_pkg::*;

    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [15:0] rdata_q;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_low_byte;
    logic        wr_is_cmd;
    logic        wr_mapped;
    logic [15:0] rd_word;

    logic [1:0]  coin_counter_q;
    logic        soft_flip_q;
    logic        color_blank_q;
    logic        bus_request_q;
    logic        bank_enable_q;
    logic [3:0]  bank_select_q;
    logic        sound_reset_q;

    // ====================
    // Write channel
    // ====================

    assign wr_low_byte = wr_req.wstrb[0];
    assign wr_is_cmd   = wr_low_byte && (wr_req.awaddr == addr_switches_p12);
    assign wr_mapped   = (wr_req.awaddr == addr_switches_p12) ||
                         (wr_req.awaddr == addr_flags) ||
                         (wr_req.awaddr == addr_bank) ||
                         (wr_req.awaddr == addr_sound_reset);

    // Address and data are taken together; a command stalls on a full queue
    assign wr_fire = wr_req.awvalid && wr_req.wvalid && !bvalid_q && !(wr_is_cmd && cmd_full);

    assign wr_rsp.awready = wr_fire;
    assign wr_rsp.wready  = wr_fire;
    assign wr_rsp.bvalid  = bvalid_q;
    assign wr_rsp.bresp   = bresp_q;

    assign cmd_push = wr_fire && wr_is_cmd;
    assign cmd_data = wr_req.wdata[7:0];

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (wr_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_fire) begin
            bresp_q <= wr_mapped ? resp_okay : resp_slverr;
        end
    end

    // ====================
    // Control registers
    // ====================

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            coin_counter_q <= 2'b00;
            soft_flip_q    <= 1'b0;
            color_blank_q  <= 1'b0;
            bus_request_q  <= 1'b0;
            bank_enable_q  <= 1'b0;
            bank_select_q  <= 4'h0;
            sound_reset_q  <= 1'b0;
        end else if (wr_fire && wr_low_byte) begin
            case (wr_req.awaddr)
                addr_flags: begin
                    coin_counter_q <= wr_req.wdata[1:0];
                    soft_flip_q    <= ~wr_req.wdata[2];
                    color_blank_q  <= wr_req.wdata[3];
                    bus_request_q  <= ~wr_req.wdata[4];
                    bank_enable_q  <= wr_req.wdata[5];
                end
                addr_bank:        bank_select_q <= wr_req.wdata[3:0];
                addr_sound_reset: sound_reset_q <= ~wr_req.wdata[0];
                default: ;
            endcase
        end
    end

    assign sys_ctrl.coin_counter = coin_counter_q;
    assign sys_ctrl.screen_flip  = ~soft_flip_q ^ ~dip_flip;
    assign sys_ctrl.color_blank  = color_blank_q;
    assign sys_ctrl.bus_request  = bus_request_q;
    assign sys_ctrl.bank_enable  = bank_enable_q;
    assign sys_ctrl.bank_select  = bank_select_q;
    assign sys_ctrl.sound_reset  = sound_reset_q;

    // ====================
    // Read channel
    // ====================

    assign rd_fire     = rd_req.arvalid && !rvalid_q;
    assign reply_taken = rd_fire && (rd_req.araddr == addr_sound_reply);

    always_comb begin
        case (rd_req.araddr)
            addr_switches_p12: rd_word = words.switches_p12;
            addr_flags:        rd_word = words.flags;
            addr_dip:          rd_word = words.dip_low;
            addr_switches_p34: rd_word = words.switches_p34;
            addr_sound_reply:  rd_word = {reply_data, reply_data};
            default:           rd_word = unmapped_read_value;
        endcase
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (rd_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
        end
    end

    assign rd_rsp.arready = rd_fire;
    assign rd_rsp.rvalid  = rvalid_q;
    assign rd_rsp.rdata   = rdata_q;
    assign rd_rsp.rresp   = resp_okay;

    // Response must be held until the master takes it
    assert property (@(posedge clk_sys) disable iff (!reset_n)
        bvalid_q && !wr_req.bready |=> bvalid_q);

    // The stall above has to keep pushes away from a full queue
    assert property (@(posedge clk_sys) disable iff (!reset_n)
        cmd_push |-> !cmd_full);

endmodule

`default_nettype wire

// ==== source/sound_cmd_fifo.sv ====
`default_nettype none

module sound_cmd_fifo #(
    parameter int cmd_depth = 8
) (
    input  wire                    clk_sys,
    input  wire                    reset_n,
    input  wire                    flush,
    input  wire                    push,
    input  m107_io_pkg::snd_cmd_t  push_data,
    input  wire                    pop,
    output m107_io_pkg::snd_cmd_t  head,
    output logic                   full,
    output logic                   empty
);

    import m107_io_pkg::*;

    localparam int ptr_w = $clog2(cmd_depth);
    localparam int cnt_w = ptr_w + 1;

    snd_cmd_t         mem [cmd_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    logic do_push;
    logic do_pop;

    // Flush wins over both sides
    assign do_push = push && !full && !flush;
    assign do_pop  = pop && !empty && !flush;

    assign full  = (count == cnt_w'(cmd_depth));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assert property (@(posedge clk_sys) disable iff (!reset_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== source/sound_cmd_port.sv ====
`default_nettype none

module sound_cmd_port (
    input  wire                    clk_sys,
    input  wire                    reset_n,

    // Queue side
    input  m107_io_pkg::snd_cmd_t  head,
    input  wire                    empty,
    output logic                   pop,

    // Sound CPU side
    output m107_io_pkg::snd_cmd_t  snd_cmd,
    output logic                   snd_cmd_valid,
    input  wire                    snd_cmd_ack,
    input  wire                    snd_reply_wr,
    input  m107_io_pkg::snd_cmd_t  snd_reply_data,

    // Main CPU side
    input  wire                    reply_taken,
    output m107_io_pkg::snd_cmd_t  reply_data,
    output logic                   snd_irq
);

    import m107_io_pkg::*;

    snd_cmd_t reply_q;
    logic     irq_q;

    // ====================
    // Command path
    // ====================

    assign snd_cmd       = head;
    assign snd_cmd_valid = !empty;

    // Stray acks with nothing queued are dropped here
    assign pop = snd_cmd_ack && !empty;

    // ====================
    // Reply latch
    // ====================

    always_ff @(posedge clk_sys) begin
        if (snd_reply_wr) begin
            reply_q <= snd_reply_data;
        end
    end

    // A fresh reply beats the CPU taking the old one
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            irq_q <= 1'b0;
        end else if (snd_reply_wr) begin
            irq_q <= 1'b1;
        end else if (reply_taken) begin
            irq_q <= 1'b0;
        end
    end

    assign reply_data = reply_q;
    assign snd_irq    = irq_q;

endmodule

`default_nettype wire

// ==== source/m107_io.sv ====
`default_nettype none

module m107_io #(
    parameter int cmd_depth = 8
) (
    input  wire                          clk_sys,
    input  wire                          reset_n,

    input  m107_io_pkg::axil_wr_req_t    wr_req,
    output m107_io_pkg::axil_wr_rsp_t    wr_rsp,
    input  m107_io_pkg::axil_rd_req_t    rd_req,
    output m107_io_pkg::axil_rd_rsp_t    rd_rsp,

    input  m107_io_pkg::player_inputs_t  inputs,
    input  wire                          kick_harness,
    input  wire [23:0]                   dip_sw,
    input  wire                          dma_busy,

    output m107_io_pkg::sys_ctrl_t       sys_ctrl,

    output m107_io_pkg::snd_cmd_t        snd_cmd,
    output logic                         snd_cmd_valid,
    input  wire                          snd_cmd_ack,
    input  wire                          snd_reply_wr,
    input  m107_io_pkg::snd_cmd_t        snd_reply_data,
    output logic                         snd_irq
);

    import m107_io_pkg::*;

    io_read_words_t words;
    sys_ctrl_t      ctrl;

    logic     cmd_push;
    snd_cmd_t cmd_data;
    logic     cmd_full;
    logic     cmd_empty;
    logic     cmd_pop;
    snd_cmd_t cmd_head;
    snd_cmd_t reply_data;
    logic     reply_taken;

    assign sys_ctrl = ctrl;

    switch_mapper u_switch_mapper (
        .inputs       (inputs),
        .kick_harness (kick_harness),
        .dip_sw       (dip_sw),
        .dma_busy     (dma_busy),
        .words        (words)
    );

    io_port_decoder u_decoder (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp),
        .words       (words),
        .dip_flip    (dip_sw[8]),
        .sys_ctrl    (ctrl),
        .cmd_push    (cmd_push),
        .cmd_data    (cmd_data),
        .cmd_full    (cmd_full),
        .reply_data  (reply_data),
        .reply_taken (reply_taken)
    );

    // Sound reset also flushes anything still queued
    sound_cmd_fifo #(
        .cmd_depth (cmd_depth)
    ) u_cmd_fifo (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .flush     (ctrl.sound_reset),
        .push      (cmd_push),
        .push_data (cmd_data),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .full      (cmd_full),
        .empty     (cmd_empty)
    );

    sound_cmd_port u_cmd_port (
        .clk_sys        (clk_sys),
        .reset_n        (reset_n),
        .head           (cmd_head),
        .empty          (cmd_empty),
        .pop            (cmd_pop),
        .snd_cmd        (snd_cmd),
        .snd_cmd_valid  (snd_cmd_valid),
        .snd_cmd_ack    (snd_cmd_ack),
        .snd_reply_wr   (snd_reply_wr),
        .snd_reply_data (snd_reply_data),
        .reply_taken    (reply_taken),
        .reply_data     (reply_data),
        .snd_irq        (snd_irq)
    );

endmodule

`default_nettype wire

// ==== tb/m107_io_model.svh ====
`ifndef M107_IO_MODEL_SVH
`define M107_IO_MODEL_SVH

// Player byte in board bit order before the active low inversion
function automatic logic [7:0] switch_byte(input logic [9:0] p, input logic bit4,
                                           input logic bit5);
    logic [7:0] b;
    b[3:0] = p[3:0];
    b[4]   = bit4;
    b[5]   = bit5;
    b[6]   = p[5];
    b[7]   = p[4];
    return b;
endfunction

function automatic logic [15:0] p12_word(input player_inputs_t in, input logic kick);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = switch_byte(in.p1, 1'b0, kick & in.p1[6]);
    hi = switch_byte(in.p2, 1'b0, kick & in.p2[6]);
    return ~{hi, lo};
endfunction

function automatic logic [15:0] p34_word(input player_inputs_t in, input logic kick);
    logic [7:0] lo;
    logic [7:0] hi;
    if (kick) begin
        // Buttons 8 to 10 of players 1 and 2 land in the player 4 byte
        lo      = 8'h00;
        hi      = 8'h00;
        hi[3:1] = in.p1[9:7];
        hi[7:5] = in.p2[9:7];
    end else begin
        lo = switch_byte(in.p3, in.start[2], in.coin[2]);
        hi = switch_byte(in.p4, in.start[3], in.coin[3]);
    end
    return ~{hi, lo};
endfunction

function automatic logic [15:0] flags_word(input player_inputs_t in, input logic [23:0] dip,
                                           input logic dma);
    logic [15:0] w;
    w[15:8] = ~dip[23:16];
    w[7]    = ~dma;
    w[6:4]  = 3'b111;
    w[3]    = ~in.coin[1];
    w[2]    = ~in.coin[0];
    w[1]    = ~in.start[1];
    w[0]    = ~in.start[0];
    return w;
endfunction

function automatic logic [15:0] dip_word(input logic [23:0] dip);
    return ~dip[15:0];
endfunction

// Control outputs from the last written register bits
function automatic sys_ctrl_t ctrl_outputs(input logic [5:0] sys_bits, input logic [3:0] bank,
                                           input logic reset_bit, input logic dip8);
    sys_ctrl_t c;
    logic      soft_flip;
    soft_flip      = ~sys_bits[2];
    c.coin_counter = sys_bits[1:0];
    c.screen_flip  = ~soft_flip ^ ~dip8;
    c.color_blank  = sys_bits[3];
    c.bus_request  = ~sys_bits[4];
    c.bank_enable  = sys_bits[5];
    c.bank_select  = bank;
    c.sound_reset  = ~reset_bit;
    return c;
endfunction

function automatic logic [1:0] write_resp_for(input logic [7:0] addr);
    case (addr)
        8'h00, 8'h02, 8'h20, 8'hc0: return 2'b00;
        default:                    return 2'b10;
    endcase
endfunction

function automatic logic [15:0] reply_word(input logic [7:0] b);
    return {b, b};
endfunction

`endif

// ==== tb/m107_io_tb.sv ====
`default_nettype none

module m107_io_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import m107_io_pkg::*;

    `include "m107_io_model.svh"

    localparam int cmd_depth = 8;
    // About four times the cycles the whole sequence needs
    localparam int timeout_cycles = 4000;

    logic           clk_sys;
    logic           reset_n;
    axil_wr_req_t   wr_req;
    axil_wr_rsp_t   wr_rsp;
    axil_rd_req_t   rd_req;
    axil_rd_rsp_t   rd_rsp;
    player_inputs_t inputs;
    logic           kick_harness;
    logic [23:0]    dip_sw;
    logic           dma_busy;
    sys_ctrl_t      sys_ctrl;
    snd_cmd_t       snd_cmd;
    logic           snd_cmd_valid;
    logic           snd_cmd_ack;
    logic           snd_reply_wr;
    snd_cmd_t       snd_reply_data;
    logic           snd_irq;

    snd_cmd_t   exp_cmds[$];
    logic [5:0] exp_sys_bits;
    logic [3:0] exp_bank;
    logic       exp_reset_bit;
    int         cycle_count = 0;

    m107_io #(.cmd_depth(cmd_depth)) uut (.*);

    always #2 clk_sys = ~clk_sys;

    // ====================
    // Helpers
    // ====================

    task automatic stop_failed;
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, want);
            stop_failed();
        end
    endtask

    task automatic next_cycle;
        @(posedge clk_sys);
        #1;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [15:0] data,
                             input logic [1:0] strb, output logic [1:0] resp);
        wr_req.awvalid = 1'b1;
        wr_req.awaddr  = addr;
        wr_req.wvalid  = 1'b1;
        wr_req.wdata   = data;
        wr_req.wstrb   = strb;
        @(negedge clk_sys);
        while (!wr_rsp.awready) @(negedge clk_sys);
        check_value("wready", 32'(wr_rsp.wready), 32'd1);
        next_cycle();
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        @(negedge clk_sys);
        while (!wr_rsp.bvalid) @(negedge clk_sys);
        resp = wr_rsp.bresp;
        next_cycle();
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [15:0] data,
                            output logic [1:0] resp);
        rd_req.arvalid = 1'b1;
        rd_req.araddr  = addr;
        @(negedge clk_sys);
        while (!rd_rsp.arready) @(negedge clk_sys);
        next_cycle();
        rd_req.arvalid = 1'b0;
        @(negedge clk_sys);
        while (!rd_rsp.rvalid) @(negedge clk_sys);
        data = rd_rsp.rdata;
        resp = rd_rsp.rresp;
        next_cycle();
    endtask

    task automatic send_command(input snd_cmd_t cmd);
        logic [1:0] resp;
        exp_cmds.push_back(cmd);
        write_reg(8'h00, {8'h5a, cmd}, 2'b11, resp);
        check_value("bresp", 32'(resp), 32'(write_resp_for(8'h00)));
    endtask

    task automatic ack_command;
        @(negedge clk_sys);
        while (!snd_cmd_valid) @(negedge clk_sys);
        next_cycle();
        snd_cmd_ack = 1'b1;
        next_cycle();
        snd_cmd_ack = 1'b0;
    endtask

    task automatic check_ctrl;
        @(negedge clk_sys);
        check_value("sys_ctrl", 32'(sys_ctrl),
                    32'(ctrl_outputs(exp_sys_bits, exp_bank, exp_reset_bit, dip_sw[8])));
        next_cycle();
    endtask

    // Sound side sees the queue head in order on each ack
    always @(negedge clk_sys) begin
        if (snd_cmd_valid && snd_cmd_ack) begin
            if (exp_cmds.size() == 0) begin
                $display("sound command 0x%0h delivered with none pending", snd_cmd);
                stop_failed();
            end else begin
                check_value("snd_cmd", 32'(snd_cmd), 32'(exp_cmds.pop_front()));
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            stop_failed();
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin : main
        logic [63:0] rnd;
        logic [31:0] r32;
        logic [15:0] data;
        logic [15:0] wdata;
        logic [7:0]  addr;
        logic [1:0]  strb;
        logic [1:0]  resp;
        snd_cmd_t    reply;

        void'($urandom(32'h27b));
        clk_sys        = 1'b0;
        reset_n        = 1'b0;
        wr_req         = '0;
        wr_req.bready  = 1'b1;
        rd_req         = '0;
        rd_req.rready  = 1'b1;
        inputs         = '0;
        kick_harness   = 1'b0;
        dip_sw         = '0;
        dma_busy       = 1'b0;
        snd_cmd_ack    = 1'b0;
        snd_reply_wr   = 1'b0;
        snd_reply_data = '0;
        // Register bits that give the reset state of sys_ctrl
        exp_sys_bits   = 6'b010100;
        exp_bank       = 4'h0;
        exp_reset_bit  = 1'b1;
        repeat (3) @(posedge clk_sys);
        #1;
        reset_n = 1'b1;

        @(negedge clk_sys);
        check_value("reset outputs", 32'({wr_rsp.bvalid, rd_rsp.rvalid, wr_rsp.awready,
                    wr_rsp.wready, rd_rsp.arready, snd_cmd_valid, snd_irq, sys_ctrl}), 32'd0);
        next_cycle();

        // Read words in both harness modes
        for (int mode = 0; mode < 2; mode++) begin
            kick_harness = mode[0];
            repeat (20) begin
                rnd      = {$urandom, $urandom};
                r32      = $urandom;
                inputs   = rnd[47:0];
                dip_sw   = r32[23:0];
                dma_busy = r32[31];
                read_reg(8'h00, data, resp);
                check_value("rdata p12", 32'(data), 32'(p12_word(inputs, kick_harness)));
                read_reg(8'h02, data, resp);
                check_value("rdata flags", 32'(data), 32'(flags_word(inputs, dip_sw, dma_busy)));
                read_reg(8'h04, data, resp);
                check_value("rdata dip", 32'(data), 32'(dip_word(dip_sw)));
                read_reg(8'h06, data, resp);
                check_value("rdata p34", 32'(data), 32'(p34_word(inputs, kick_harness)));
                // Odd addresses are never mapped
                read_reg({r32[30:24], 1'b1}, data, resp);
                check_value("rdata unmapped", 32'(data), 32'hffff);
                check_value("rresp", 32'(resp), 32'(resp_okay));
            end
        end

        // Control register writes
        for (int i = 0; i < 24; i++) begin
            r32       = $urandom;
            dip_sw[8] = i[0];
            case (r32[1:0])
                2'd0:    addr = 8'h02;
                2'd1:    addr = 8'h20;
                default: addr = 8'hc0;
            endcase
            wdata = r32[23:8];
            strb  = {r32[24], r32[26:25] != 2'b00};
            write_reg(addr, wdata, strb, resp);
            check_value("bresp", 32'(resp), 32'(write_resp_for(addr)));
            if (strb[0]) begin
                case (addr)
                    8'h02:   exp_sys_bits = wdata[5:0];
                    8'h20:   exp_bank = wdata[3:0];
                    default: exp_reset_bit = wdata[0];
                endcase
            end
            check_ctrl();
        end
        // Upper strobe only, with data that would change the bank
        write_reg(8'h20, {12'h000, ~exp_bank}, 2'b10, resp);
        check_value("bresp", 32'(resp), 32'(write_resp_for(8'h20)));
        check_ctrl();
        write_reg(8'h40, 16'hffff, 2'b11, resp);
        check_value("bresp", 32'(resp), 32'(write_resp_for(8'h40)));
        check_ctrl();
        write_reg(8'hc0, 16'h0001, 2'b11, resp);
        exp_reset_bit = 1'b1;
        check_ctrl();

        // Commands with random acks in between
        for (int i = 0; i < 16; i++) begin
            if (exp_cmds.size() == cmd_depth || (exp_cmds.size() != 0 && $urandom % 3 == 0)) begin
                ack_command();
            end
            r32 = $urandom;
            send_command(r32[7:0]);
        end
        while (exp_cmds.size() != 0) ack_command();
        @(negedge clk_sys);
        check_value("snd_cmd_valid", 32'(snd_cmd_valid), 32'd0);
        next_cycle();

        // Full queue stalls the next command until one ack
        repeat (cmd_depth) begin
            r32 = $urandom;
            send_command(r32[7:0]);
        end
        r32 = $urandom;
        fork
            send_command(r32[7:0]);
            begin
                repeat (20) begin
                    @(negedge clk_sys);
                    check_value("awready", 32'(wr_rsp.awready), 32'd0);
                end
                ack_command();
            end
        join
        while (exp_cmds.size() != 0) ack_command();

        // Reply latch and sound interrupt
        r32            = $urandom;
        reply          = r32[7:0];
        snd_reply_wr   = 1'b1;
        snd_reply_data = reply;
        next_cycle();
        snd_reply_wr = 1'b0;
        @(negedge clk_sys);
        check_value("snd_irq", 32'(snd_irq), 32'd1);
        next_cycle();
        read_reg(8'h08, data, resp);
        check_value("rdata reply", 32'(data), 32'(reply_word(reply)));
        @(negedge clk_sys);
        check_value("snd_irq", 32'(snd_irq), 32'd0);
        next_cycle();

        // Sound reset flushes the queue
        repeat (3) begin
            r32 = $urandom;
            send_command(r32[7:0]);
        end
        write_reg(8'hc0, 16'h0000, 2'b01, resp);
        exp_reset_bit = 1'b0;
        exp_cmds.delete();
        check_value("snd_cmd_valid", 32'(snd_cmd_valid), 32'd0);
        check_ctrl();
        write_reg(8'hc0, 16'h0001, 2'b01, resp);
        exp_reset_bit = 1'b1;
        check_ctrl();
        check_value("snd_cmd_valid", 32'(snd_cmd_valid), 32'd0);
        repeat (2) begin
            r32 = $urandom;
            send_command(r32[7:0]);
        end
        while (exp_cmds.size() != 0) ack_command();
        @(negedge clk_sys);
        check_value("snd_cmd_valid", 32'(snd_cmd_valid), 32'd0);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tb
source/m107_io_pkg.sv
source/switch_mapper.sv
source/io_port_decoder.sv
source/sound_cmd_fifo.sv
source/sound_cmd_port.sv
source/m107_io.sv
tb/m107_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f --top-module m107_io_tb \
    -Mdir obj_dir -o m107_io_sim \
    && ./obj_dir/m107_io_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
